//--- include/ipv4_defs.svh
`ifndef IPV4_DEFS_SVH
`define IPV4_DEFS_SVH

// Fixed IPv4 header without options, in bytes
`define IPV4_HDR_BYTES 20

// Ethertype that the MAC reports for IPv4
`define IPV4_ETHERTYPE 16'h0800

// Limited broadcast destination
`define IPV4_BROADCAST 32'hFFFFFFFF

// Largest total length accepted
`define IPV4_MAX_LEN 1500

// Width of the accepted and dropped packet counters
`define IPV4_CNT_W 16

`endif

//--- ipv4_rx_top.f
+incdir+include
source/ipv4_pkg.sv
source/mac_rx_gate.sv
source/ipv4_rx.sv
source/ipv4_pld_out.sv
source/ipv4_rx_top.sv
test/ipv4_rx_sva.sv
test/ipv4_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ipv4_rx_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f ipv4_rx_top.f \
  --top-module ipv4_rx_tb \
  -o ipv4_rx_sim

# The simulator exits non-zero on a fatal error; the log decides the result
./obj_dir/ipv4_rx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- source/ipv4_pkg.sv
`include "ipv4_defs.svh"

package ipv4_pkg;

  typedef logic [7:0]             byte_t;
  typedef logic [15:0]            ethertype_t;
  typedef logic [31:0]            ip_addr_t;
  typedef logic [15:0]            ip_len_t;
  typedef logic [7:0]             ip_proto_t;
  typedef logic [`IPV4_CNT_W-1:0] pkt_cnt_t;

  // Why a header or a frame was rejected
  typedef enum logic [2:0] {
    DROP_NONE     = 3'd0,
    DROP_VERSION  = 3'd1,
    DROP_CHECKSUM = 3'd2,
    DROP_LENGTH   = 3'd3,
    DROP_FRAGMENT = 3'd4,
    DROP_ADDRESS  = 3'd5,
    DROP_TRUNC    = 3'd6
  } drop_reason_t;

  typedef enum logic [1:0] {
    GATE_IDLE,
    GATE_PASS,
    GATE_DISCARD
  } gate_state_t;

  typedef enum logic [1:0] {
    RX_HDR,
    RX_PLD,
    RX_SKIP
  } rx_state_t;

endpackage

//--- source/ipv4_pld_out.sv
`timescale 1ns/1ps

module ipv4_pld_out
  import ipv4_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  input  byte_t        rx_dat,
  input  logic         rx_val,
  input  logic         rx_sof,
  input  logic         rx_eof,
  input  logic         rx_err,
  input  logic         hdr_ok,
  input  logic         hdr_drop,
  input  drop_reason_t hdr_reason,
  input  ip_addr_t     hdr_src,
  input  ip_proto_t    hdr_proto,
  input  ip_len_t      hdr_pld_len,
  output byte_t        pld_dat,
  output logic         pld_val,
  output logic         pld_sof,
  output logic         pld_eof,
  output logic         pld_err,
  output logic         pkt_done,
  output ip_addr_t     pkt_src,
  output ip_proto_t    pkt_proto,
  output ip_len_t      pkt_len,
  output logic         drop_pulse,
  output drop_reason_t drop_reason,
  output pkt_cnt_t     acc_cnt,
  output pkt_cnt_t     drop_cnt
);

  logic pld_trunc;

  assign pld_trunc = pld_eof && pld_err;

  always_ff @(posedge clk) begin
    pld_dat <= rx_dat;
    // Metadata stays put until the next accepted header
    if (hdr_ok) begin
      pkt_src   <= hdr_src;
      pkt_proto <= hdr_proto;
      pkt_len   <= hdr_pld_len;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pld_val     <= 1'b0;
      pld_sof     <= 1'b0;
      pld_eof     <= 1'b0;
      pld_err     <= 1'b0;
      pkt_done    <= 1'b0;
      drop_pulse  <= 1'b0;
      drop_reason <= DROP_NONE;
      acc_cnt     <= '0;
      drop_cnt    <= '0;
    end else begin
      pld_val    <= rx_val;
      pld_sof    <= rx_sof;
      pld_eof    <= rx_eof;
      pld_err    <= rx_err;
      // Empty packets complete on the header itself
      pkt_done   <= (rx_val && rx_eof && !rx_err) || (hdr_ok && hdr_pld_len == '0);
      drop_pulse <= hdr_drop;
      if (hdr_drop) drop_reason <= hdr_reason;
      if (pkt_done) acc_cnt <= acc_cnt + pkt_cnt_t'(1);
      drop_cnt <= drop_cnt + pkt_cnt_t'(drop_pulse) + pkt_cnt_t'(pld_trunc);
    end
  end

endmodule

//--- source/ipv4_rx.sv
`timescale 1ns/1ps
`include "ipv4_defs.svh"

module ipv4_rx
  import ipv4_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  input  byte_t        gate_dat,
  input  logic         gate_val,
  input  logic         gate_sof,
  input  logic         gate_eof,
  input  ip_addr_t     dev_ip,
  output byte_t        rx_dat,
  output logic         rx_val,
  output logic         rx_sof,
  output logic         rx_eof,
  output logic         rx_err,
  output logic         hdr_ok,
  output logic         hdr_drop,
  output drop_reason_t hdr_reason,
  output ip_addr_t     hdr_src,
  output ip_proto_t    hdr_proto,
  output ip_len_t      hdr_pld_len
);

  localparam int LAST_HDR = `IPV4_HDR_BYTES - 1;

  rx_state_t    state;
  rx_state_t    eff_state;
  logic [4:0]   hdr_cnt;
  logic [4:0]   eff_cnt;
  byte_t        hdr [LAST_HDR];
  byte_t        cks_hi;
  logic [15:0]  cks;
  logic [16:0]  cks_sum;
  logic [15:0]  cks_next;
  ip_len_t      pld_left;
  logic         restart;
  logic         is_open;
  logic         abort_old;
  logic         byte_last;
  logic         hdr_byte;
  logic         hdr_last;
  byte_t        ver_ihl;
  ip_len_t      tot_len;
  logic [15:0]  frag;
  ip_addr_t     dst_ip;
  drop_reason_t reason;

  // A sof byte always starts a fresh header, whatever state we were in
  assign restart   = gate_val && gate_sof;
  assign eff_state = restart ? RX_HDR : state;
  assign eff_cnt   = restart ? 5'd0 : hdr_cnt;
  assign is_open   = (state != RX_HDR) || (hdr_cnt != 5'd0);

  // A forced eof from the gate ends the open frame without a byte of its own
  assign abort_old = is_open && gate_eof && (restart || !gate_val);
  assign byte_last = gate_val && gate_eof && !abort_old;

  assign hdr_byte  = gate_val && (eff_state == RX_HDR);
  assign hdr_last  = hdr_byte && (eff_cnt == 5'(LAST_HDR));

  // hdr[0] holds the newest byte, so header byte j sits at hdr[18-j]
  // until byte 19 arrives on gate_dat
  assign ver_ihl = hdr[18];
  assign tot_len = {hdr[16], hdr[15]};
  assign frag    = {hdr[12], hdr[11]};
  assign dst_ip  = {hdr[2], hdr[1], hdr[0], gate_dat};

  // Ones'-complement add of the current word with the end-around carry folded back
  assign cks_sum  = {1'b0, cks} + {1'b0, cks_hi, gate_dat};
  assign cks_next = cks_sum[15:0] + {15'd0, cks_sum[16]};

  always_comb begin
    if (ver_ihl != 8'h45) begin
      reason = DROP_VERSION;
    end else if (tot_len < ip_len_t'(`IPV4_HDR_BYTES) ||
                 tot_len > ip_len_t'(`IPV4_MAX_LEN)) begin
      reason = DROP_LENGTH;
    end else if (cks_next != 16'hFFFF) begin
      reason = DROP_CHECKSUM;
    end else if (frag[13] || (frag[12:0] != 13'd0)) begin
      reason = DROP_FRAGMENT;
    end else if (dst_ip != dev_ip && dst_ip != `IPV4_BROADCAST) begin
      reason = DROP_ADDRESS;
    end else begin
      reason = DROP_NONE;
    end
  end

  always_ff @(posedge clk) begin
    rx_dat <= gate_dat;
    if (hdr_byte) begin
      hdr[0] <= gate_dat;
      for (int i = 1; i < LAST_HDR; i++) begin
        hdr[i] <= hdr[i-1];
      end
      if (!eff_cnt[0]) cks_hi <= gate_dat;
    end
    if (hdr_last && reason == DROP_NONE) begin
      hdr_src     <= {hdr[6], hdr[5], hdr[4], hdr[3]};
      hdr_proto   <= hdr[9];
      hdr_pld_len <= tot_len - ip_len_t'(`IPV4_HDR_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= RX_HDR;
      hdr_cnt    <= 5'd0;
      cks        <= 16'd0;
      pld_left   <= '0;
      rx_val     <= 1'b0;
      rx_sof     <= 1'b0;
      rx_eof     <= 1'b0;
      rx_err     <= 1'b0;
      hdr_ok     <= 1'b0;
      hdr_drop   <= 1'b0;
      hdr_reason <= DROP_NONE;
    end else begin
      rx_val   <= 1'b0;
      rx_sof   <= 1'b0;
      rx_eof   <= 1'b0;
      rx_err   <= 1'b0;
      hdr_ok   <= 1'b0;
      hdr_drop <= 1'b0;

      if (abort_old) begin
        state   <= RX_HDR;
        hdr_cnt <= 5'd0;
        if (state == RX_HDR) begin
          hdr_drop   <= 1'b1;
          hdr_reason <= DROP_TRUNC;
        end else if (state == RX_PLD) begin
          // Error beat; its data byte means nothing
          rx_val <= 1'b1;
          rx_eof <= 1'b1;
          rx_err <= 1'b1;
        end
      end

      if (gate_val) begin
        case (eff_state)
          RX_HDR: begin
            if (eff_cnt[0]) cks <= cks_next;
            else if (eff_cnt == 5'd0) cks <= 16'd0;
            if (hdr_last) begin
              hdr_cnt <= 5'd0;
              if (reason == DROP_NONE) begin
                hdr_ok   <= 1'b1;
                pld_left <= tot_len - ip_len_t'(`IPV4_HDR_BYTES);
                if (byte_last) begin
                  state <= RX_HDR;
                  // Payload expected but the frame is already over
                  if (tot_len != ip_len_t'(`IPV4_HDR_BYTES)) begin
                    rx_val <= 1'b1;
                    rx_eof <= 1'b1;
                    rx_err <= 1'b1;
                  end
                end else if (tot_len == ip_len_t'(`IPV4_HDR_BYTES)) begin
                  state <= RX_SKIP;
                end else begin
                  state <= RX_PLD;
                end
              end else begin
                hdr_drop   <= 1'b1;
                hdr_reason <= reason;
                state      <= byte_last ? RX_HDR : RX_SKIP;
              end
            end else if (byte_last) begin
              hdr_cnt    <= 5'd0;
              state      <= RX_HDR;
              hdr_drop   <= 1'b1;
              hdr_reason <= DROP_TRUNC;
            end else begin
              hdr_cnt <= eff_cnt + 5'd1;
              state   <= RX_HDR;
            end
          end
          RX_PLD: begin
            rx_val   <= 1'b1;
            rx_sof   <= (pld_left == hdr_pld_len);
            pld_left <= pld_left - ip_len_t'(1);
            if (pld_left == ip_len_t'(1)) begin
              rx_eof <= 1'b1;
              state  <= byte_last ? RX_HDR : RX_SKIP;
            end else if (byte_last) begin
              rx_eof <= 1'b1;
              rx_err <= 1'b1;
              state  <= RX_HDR;
            end
          end
          // Padding, or the rest of a dropped packet
          default: begin
            if (byte_last) state <= RX_HDR;
          end
        endcase
      end
    end
  end

endmodule

//--- source/ipv4_rx_top.sv
`timescale 1ns/1ps

module ipv4_rx_top
  import ipv4_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  input  byte_t        mac_dat,
  input  logic         mac_val,
  input  logic         mac_sof,
  input  logic         mac_eof,
  input  ethertype_t   mac_ethertype,
  input  ip_addr_t     dev_ip,
  output byte_t        pld_dat,
  output logic         pld_val,
  output logic         pld_sof,
  output logic         pld_eof,
  output logic         pld_err,
  output logic         pkt_done,
  output ip_addr_t     pkt_src,
  output ip_proto_t    pkt_proto,
  output ip_len_t      pkt_len,
  output logic         drop_pulse,
  output drop_reason_t drop_reason,
  output pkt_cnt_t     acc_cnt,
  output pkt_cnt_t     drop_cnt
);

  byte_t        gate_dat;
  logic         gate_val;
  logic         gate_sof;
  logic         gate_eof;
  byte_t        rx_dat;
  logic         rx_val;
  logic         rx_sof;
  logic         rx_eof;
  logic         rx_err;
  logic         hdr_ok;
  logic         hdr_drop;
  drop_reason_t hdr_reason;
  ip_addr_t     hdr_src;
  ip_proto_t    hdr_proto;
  ip_len_t      hdr_pld_len;

  mac_rx_gate mac_rx_gate_inst (.*);

  ipv4_rx ipv4_rx_inst (.*);

  ipv4_pld_out ipv4_pld_out_inst (.*);

endmodule

//--- source/mac_rx_gate.sv
`timescale 1ns/1ps
`include "ipv4_defs.svh"

module mac_rx_gate
  import ipv4_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  byte_t      mac_dat,
  input  logic       mac_val,
  input  logic       mac_sof,
  input  logic       mac_eof,
  input  ethertype_t mac_ethertype,
  output byte_t      gate_dat,
  output logic       gate_val,
  output logic       gate_sof,
  output logic       gate_eof
);

  gate_state_t state;
  logic        is_ipv4;

  assign is_ipv4 = (mac_ethertype == `IPV4_ETHERTYPE);

  always_ff @(posedge clk) begin
    gate_dat <= mac_dat;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= GATE_IDLE;
      gate_val <= 1'b0;
      gate_sof <= 1'b0;
      gate_eof <= 1'b0;
    end else begin
      gate_val <= 1'b0;
      gate_sof <= 1'b0;
      gate_eof <= 1'b0;
      if (mac_val && mac_sof) begin
        // A sof inside an open IPv4 frame closes it with a forced eof.
        // On a passed sof byte that eof belongs to the old frame, not to this byte
        if (is_ipv4) begin
          gate_val <= 1'b1;
          gate_sof <= 1'b1;
          gate_eof <= mac_eof || (state == GATE_PASS);
          state    <= mac_eof ? GATE_IDLE : GATE_PASS;
        end else begin
          gate_eof <= (state == GATE_PASS);
          state    <= mac_eof ? GATE_IDLE : GATE_DISCARD;
        end
      end else if (mac_val) begin
        case (state)
          GATE_PASS: begin
            gate_val <= 1'b1;
            gate_eof <= mac_eof;
            if (mac_eof) state <= GATE_IDLE;
          end
          GATE_DISCARD: begin
            if (mac_eof) state <= GATE_IDLE;
          end
          // Stray bytes outside a frame are ignored
          default: state <= GATE_IDLE;
        endcase
      end
    end
  end

endmodule

//--- test/ipv4_rx_sva.sv
`timescale 1ns/1ps

module ipv4_rx_sva (
  input logic clk,
  input logic fsm_rst,
  input logic pld_val,
  input logic pld_sof,
  input logic pld_eof,
  input logic pld_err,
  input logic pkt_done,
  input logic drop_pulse
);

  sof_eof_with_val: assert property (@(posedge clk) disable iff (fsm_rst)
    (pld_sof || pld_eof) |-> pld_val)
    else $error("pld_sof or pld_eof without pld_val");

  done_drop_exclusive: assert property (@(posedge clk) disable iff (fsm_rst)
    !(pkt_done && drop_pulse))
    else $error("pkt_done and drop_pulse high together");

  quiet_after_reset: assert property (@(posedge clk)
    fsm_rst |=> !(pld_val || pld_sof || pld_eof || pld_err || pkt_done || drop_pulse))
    else $error("Output active in the cycle after reset");

  err_with_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    pld_err |-> pld_eof)
    else $error("pld_err without pld_eof");

endmodule

bind ipv4_rx_top ipv4_rx_sva ipv4_rx_sva_inst (.*);

//--- test/ipv4_rx_tb.sv
`timescale 1ns/1ps
`include "ipv4_defs.svh"

module ipv4_rx_tb
  import ipv4_pkg::*;
();

  localparam int NUM_FRAMES = 300;
  localparam int EV_ACC = 0;
  localparam int EV_TRUNC = 1;
  localparam int EV_DROP = 2;

  logic clk = 1'b0;
  logic fsm_rst;
  byte_t mac_dat;
  logic mac_val, mac_sof, mac_eof;
  ethertype_t mac_ethertype;
  ip_addr_t dev_ip;
  byte_t pld_dat;
  logic pld_val, pld_sof, pld_eof, pld_err, pkt_done, drop_pulse;
  ip_addr_t pkt_src;
  ip_proto_t pkt_proto;
  ip_len_t pkt_len;
  drop_reason_t drop_reason;
  pkt_cnt_t acc_cnt, drop_cnt;

  int cyc = 0;
  int acc_exp = 0;
  int drop_exp = 0;
  byte_t frame[$];
  bit emit[$];
  // Expected output beats and per-packet results
  byte_t b_dat[$];
  bit b_sof[$], b_eof[$], b_err[$], b_dc[$];
  int b_stamp[$];
  int ev_kind[$];
  ip_addr_t ev_src[$];
  ip_proto_t ev_proto[$];
  ip_len_t ev_len[$];
  drop_reason_t ev_reason[$];

  ipv4_rx_top ipv4_rx_top_inst (.*);

  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic cmp_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_addr(input string name, input ip_addr_t got, input ip_addr_t exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_proto(input string name, input ip_proto_t got, input ip_proto_t exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_len(input string name, input ip_len_t got, input ip_len_t exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_reason(input string name, input drop_reason_t got,
                            input drop_reason_t exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_cnt(input string name, input pkt_cnt_t got, input pkt_cnt_t exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic cmp_int(input string name, input int got, input int exp);
    if (got != exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic logic [15:0] header_sum(input int skip_cks);
    logic [16:0] s;
    logic [15:0] w;
    s = 17'd0;
    for (int i = 0; i < `IPV4_HDR_BYTES; i += 2) begin
      w = (skip_cks != 0 && i == 10) ? 16'd0 : {frame[i], frame[i+1]};
      s = {1'b0, s[15:0]} + {1'b0, w};
      s = {1'b0, s[15:0]} + {16'd0, s[16]};
    end
    return s[15:0];
  endfunction

  task automatic push_beat(input byte_t d, input bit sof, input bit eof, input bit err,
                           input bit dc);
    b_dat.push_back(d);
    b_sof.push_back(sof);
    b_eof.push_back(eof);
    b_err.push_back(err);
    b_dc.push_back(dc);
  endtask

  task automatic push_event(input int kind, input drop_reason_t reason);
    ev_kind.push_back(kind);
    ev_src.push_back({frame[12], frame[13], frame[14], frame[15]});
    ev_proto.push_back(frame[9]);
    ev_len.push_back(ip_len_t'({frame[2], frame[3]}) - ip_len_t'(`IPV4_HDR_BYTES));
    ev_reason.push_back(reason);
  endtask

  // Reference model of one frame that decides what the DUT must report
  task automatic model_frame();
    int n;
    int pl;
    int tot;
    ip_addr_t dst;
    drop_reason_t r;
    n = frame.size();
    emit = {};
    for (int i = 0; i < n; i++) emit.push_back(1'b0);
    if (mac_ethertype != `IPV4_ETHERTYPE) return;
    if (n < `IPV4_HDR_BYTES) begin
      push_event(EV_DROP, DROP_TRUNC);
      drop_exp++;
      return;
    end
    tot = {frame[2], frame[3]};
    dst = {frame[16], frame[17], frame[18], frame[19]};
    if (frame[0] != 8'h45) r = DROP_VERSION;
    else if (tot < `IPV4_HDR_BYTES || tot > `IPV4_MAX_LEN) r = DROP_LENGTH;
    else if (header_sum(0) != 16'hFFFF) r = DROP_CHECKSUM;
    else if (frame[6][5] || {frame[6][4:0], frame[7]} != 13'd0) r = DROP_FRAGMENT;
    else if (dst != dev_ip && dst != `IPV4_BROADCAST) r = DROP_ADDRESS;
    else r = DROP_NONE;
    if (r != DROP_NONE) begin
      push_event(EV_DROP, r);
      drop_exp++;
      return;
    end
    pl = tot - `IPV4_HDR_BYTES;
    if (pl == 0 || n >= tot) begin
      for (int i = 0; i < pl; i++) begin
        push_beat(frame[20+i], i == 0, i == pl - 1, 1'b0, 1'b0);
        emit[20+i] = 1'b1;
      end
      push_event(EV_ACC, DROP_NONE);
      acc_exp++;
    end else if (n == `IPV4_HDR_BYTES) begin
      // The error beat comes right after the header and carries no meaningful data
      push_beat(8'h00, 1'b0, 1'b1, 1'b1, 1'b1);
      emit[19] = 1'b1;
      push_event(EV_TRUNC, DROP_NONE);
      drop_exp++;
    end else begin
      for (int i = 20; i < n; i++) begin
        push_beat(frame[i], i == 20, i == n - 1, i == n - 1, 1'b0);
        emit[i] = 1'b1;
      end
      push_event(EV_TRUNC, DROP_NONE);
      drop_exp++;
    end
  endtask

  task automatic build_frame();
    int pl;
    int fault;
    int tot;
    int n;
    logic [15:0] cks;
    ip_addr_t dst;
    pl = ($urandom_range(0, 7) == 0) ? 0 : $urandom_range(1, 40);
    fault = $urandom_range(0, 9);
    tot = `IPV4_HDR_BYTES + pl;
    dst = dev_ip;
    frame = {};
    if (fault == 2) tot = ($urandom_range(0, 1) == 0) ? $urandom_range(0, 19) : 1600;
    if (fault == 4) dst = $urandom;
    if (fault == 5) dst = `IPV4_BROADCAST;
    frame.push_back((fault == 0) ? 8'h46 : 8'h45);
    frame.push_back(byte_t'($urandom));
    frame.push_back(byte_t'(tot >> 8));
    frame.push_back(byte_t'(tot));
    frame.push_back(byte_t'($urandom));
    frame.push_back(byte_t'($urandom));
    frame.push_back((fault == 3) ? 8'h20 : 8'h40);
    frame.push_back((fault == 3) ? byte_t'($urandom_range(0, 1)) : 8'h00);
    frame.push_back(byte_t'($urandom));
    frame.push_back(byte_t'($urandom));
    frame.push_back(8'h00);
    frame.push_back(8'h00);
    for (int i = 0; i < 4; i++) frame.push_back(byte_t'($urandom));
    for (int i = 3; i >= 0; i--) frame.push_back(dst[8*i +: 8]);
    cks = ~header_sum(1);
    frame[10] = cks[15:8];
    frame[11] = cks[7:0];
    if (fault == 1) frame[10 + $urandom_range(0, 1)] ^= byte_t'(1 << $urandom_range(0, 7));
    for (int i = 0; i < pl; i++) frame.push_back(byte_t'($urandom));
    mac_ethertype = `IPV4_ETHERTYPE;
    if (fault == 7) mac_ethertype = ($urandom_range(0, 1) == 0) ? 16'h86DD : 16'h0806;
    if (fault == 6) begin
      n = $urandom_range(1, `IPV4_HDR_BYTES + pl - 1);
      while (frame.size() > n) void'(frame.pop_back());
    end else begin
      repeat ($urandom_range(0, 8)) frame.push_back(byte_t'($urandom));
    end
  endtask

  task automatic send_frame();
    for (int i = 0; i < frame.size(); i++) begin
      while ($urandom_range(0, 3) == 0) begin
        @(negedge clk);
        mac_val = 1'b0;
      end
      @(negedge clk);
      mac_dat = frame[i];
      mac_val = 1'b1;
      mac_sof = (i == 0);
      mac_eof = (i == frame.size() - 1);
      if (emit[i]) b_stamp.push_back(cyc);
    end
    @(negedge clk);
    mac_val = 1'b0;
    mac_sof = 1'b0;
    mac_eof = 1'b0;
    repeat ($urandom_range(0, 3)) @(negedge clk);
  endtask

  // Output checker, sampled on the falling edge where outputs are stable
  always @(negedge clk) begin
    if (!fsm_rst) begin
      if (pld_val) begin
        if (b_dat.size() == 0) fail_run("A payload byte came out when none was expected");
        cmp_int("pld latency", cyc - b_stamp.pop_front(), 3);
        if (!b_dc[0]) cmp_byte("pld_dat", pld_dat, b_dat[0]);
        cmp_bit("pld_sof", pld_sof, b_sof[0]);
        cmp_bit("pld_eof", pld_eof, b_eof[0]);
        cmp_bit("pld_err", pld_err, b_err[0]);
        if (b_err[0]) begin
          if (ev_kind.size() == 0 || ev_kind[0] != EV_TRUNC)
            fail_run("A truncated payload ended where no truncation was expected");
          void'(ev_kind.pop_front());
          void'(ev_src.pop_front());
          void'(ev_proto.pop_front());
          void'(ev_len.pop_front());
          void'(ev_reason.pop_front());
        end
        void'(b_dat.pop_front());
        void'(b_sof.pop_front());
        void'(b_eof.pop_front());
        void'(b_err.pop_front());
        void'(b_dc.pop_front());
      end
      if (pkt_done) begin
        if (ev_kind.size() == 0 || ev_kind[0] != EV_ACC)
          fail_run("pkt_done came out when no accepted packet was expected");
        cmp_addr("pkt_src", pkt_src, ev_src[0]);
        cmp_proto("pkt_proto", pkt_proto, ev_proto[0]);
        cmp_len("pkt_len", pkt_len, ev_len[0]);
        cmp_bit("pld_eof", pld_eof, ev_len[0] != 0);
        void'(ev_kind.pop_front());
        void'(ev_src.pop_front());
        void'(ev_proto.pop_front());
        void'(ev_len.pop_front());
        void'(ev_reason.pop_front());
      end
      if (drop_pulse) begin
        if (ev_kind.size() == 0 || ev_kind[0] != EV_DROP)
          fail_run("drop_pulse came out when no drop was expected");
        cmp_reason("drop_reason", drop_reason, ev_reason.pop_front());
        void'(ev_kind.pop_front());
        void'(ev_src.pop_front());
        void'(ev_proto.pop_front());
        void'(ev_len.pop_front());
      end
    end
  end

  initial begin
    int waited;
    fsm_rst = 1'b1;
    mac_dat = 8'h00;
    mac_val = 1'b0;
    mac_sof = 1'b0;
    mac_eof = 1'b0;
    mac_ethertype = 16'h0000;
    void'($urandom(40088));
    dev_ip = 32'h0A00_0000 | ($urandom & 32'h00FF_FFFF);
    repeat (8) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;

    for (int f = 0; f < NUM_FRAMES; f++) begin
      build_frame();
      model_frame();
      send_frame();
    end

    waited = 0;
    while (b_dat.size() != 0 || ev_kind.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 200) fail_run("Expected payload bytes or packet results never arrived");
    end
    repeat (4) @(negedge clk);
    cmp_cnt("acc_cnt", acc_cnt, pkt_cnt_t'(acc_exp));
    cmp_cnt("drop_cnt", drop_cnt, pkt_cnt_t'(drop_exp));
    $display("RESULT: PASS");
    $finish;
  end

endmodule
